// ==== logic/exu_pkg.sv ====
package exu_pkg;

	typedef enum logic [1:0] {
		unit_alu,
		unit_branch,
		unit_mul,
		unit_div
	} exu_unit_e;

	typedef enum logic [3:0] {
		op_add,
		op_sub,
		op_sll,
		op_slt,
		op_sltu,
		op_xor,
		op_srl,
		op_sra,
		op_or,
		op_and
	} alu_op_e;

	typedef enum logic [1:0] {
		sel_rs1_rs2,
		sel_rs1_imm,
		sel_pc_4, // operand b is the constant 4
		sel_pc_imm
	} src_sel_e;

	localparam logic [2:0] f3_beq    = 3'd0;
	localparam logic [2:0] f3_bne    = 3'd1;
	localparam logic [2:0] f3_blt    = 3'd4;
	localparam logic [2:0] f3_bge    = 3'd5;
	localparam logic [2:0] f3_bltu   = 3'd6;
	localparam logic [2:0] f3_bgeu   = 3'd7;
	localparam logic [2:0] f3_mul    = 3'd0;
	localparam logic [2:0] f3_mulh   = 3'd1;
	localparam logic [2:0] f3_mulhsu = 3'd2;
	localparam logic [2:0] f3_mulhu  = 3'd3;
	localparam logic [2:0] f3_div    = 3'd4;
	localparam logic [2:0] f3_divu   = 3'd5;
	localparam logic [2:0] f3_rem    = 3'd6;
	localparam logic [2:0] f3_remu   = 3'd7;

endpackage

// ==== logic/exu_alu.sv ====
module exu_alu import exu_pkg::*; #(
	parameter int XLEN = 32
) (
	input  logic [XLEN-1:0] a,
	input  logic [XLEN-1:0] b,
	input  alu_op_e         alu_op,
	input  logic [2:0]      funct3,
	input  exu_unit_e       unit,
	output logic [XLEN-1:0] alu_result
);

	localparam int shamt_width = $clog2(XLEN);

	logic [shamt_width-1:0] shamt;
	logic                   eq;
	logic                   lt;
	logic                   ltu;
	logic                   taken;

	assign shamt = b[shamt_width-1:0];
	assign eq    = a == b;
	assign lt    = $signed(a) < $signed(b);
	assign ltu   = a < b;

	always_comb begin
		case (funct3)
			f3_beq:  taken = eq;
			f3_bne:  taken = !eq;
			f3_blt:  taken = lt;
			f3_bge:  taken = !lt;
			f3_bltu: taken = ltu;
			f3_bgeu: taken = !ltu;
			default: taken = 1'b0; // funct3 2 and 3 are not branches
		endcase
	end

	always_comb begin
		if (unit == unit_branch) begin
			alu_result = {{(XLEN-1){1'b0}}, taken};
		end else begin
			case (alu_op)
				op_add:  alu_result = a + b;
				op_sub:  alu_result = a - b;
				op_sll:  alu_result = a << shamt;
				op_slt:  alu_result = {{(XLEN-1){1'b0}}, lt};
				op_sltu: alu_result = {{(XLEN-1){1'b0}}, ltu};
				op_xor:  alu_result = a ^ b;
				op_srl:  alu_result = a >> shamt;
				op_sra:  alu_result = $signed(a) >>> shamt;
				op_or:   alu_result = a | b;
				op_and:  alu_result = a & b;
				default: alu_result = '0;
			endcase
		end
	end

endmodule

// ==== logic/exu_sequencer.sv ====
module exu_sequencer import exu_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      start,
	input  logic      flush,
	input  exu_unit_e unit,
	input  logic      count_zero,
	output logic      busy,
	output logic      result_valid,
	output logic      mul_load,
	output logic      div_load,
	output logic      count_load,
	output logic      step_en,
	output logic      capture
);

	typedef enum logic [2:0] {
		st_idle,
		st_single,
		st_iterate,
		st_finish,
		st_hold
	} state_e;

	state_e state;
	state_e state_next;
	logic   iterative;
	logic   accept;

	assign iterative = unit == unit_mul || unit == unit_div;
	// a new instruction is taken only when nothing is in flight, flush wins over start
	assign accept = start && !flush && (state == st_idle || state == st_hold);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		if (flush) begin
			state_next = st_idle;
		end else begin
			case (state)
				st_idle, st_hold: begin
					if (accept) begin
						state_next = iterative ? st_iterate : st_single;
					end
				end
				st_single:  state_next = st_hold;
				st_iterate: begin
					if (count_zero) begin
						state_next = st_finish; // this step is the last one
					end
				end
				st_finish:  state_next = st_hold;
				default:    state_next = st_idle;
			endcase
		end
	end

	assign busy         = state == st_single || state == st_iterate || state == st_finish;
	assign result_valid = state == st_hold;
	assign mul_load     = accept && unit == unit_mul;
	assign div_load     = accept && unit == unit_div;
	assign count_load   = accept && iterative;
	assign step_en      = state == st_iterate;
	assign capture      = (state == st_single || state == st_finish) && !flush;

endmodule

// ==== logic/exu_step_counter.sv ====
module exu_step_counter #(
	parameter int XLEN        = 32,
	parameter int count_width = 5
) (
	input  logic clock,
	input  logic reset,
	input  logic count_load,
	input  logic step_en,
	output logic count_zero
);

	logic [count_width-1:0] count;

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end else if (count_load) begin
			count <= count_width'(XLEN - 1);
		end else if (step_en && count != '0) begin
			count <= count - 1'b1;
		end
	end

	// high during the final step of an iteration
	assign count_zero = count == '0;

endmodule

// ==== logic/exu_multiplier.sv ====
module exu_multiplier import exu_pkg::*; #(
	parameter int XLEN = 32
) (
	input  logic            clock,
	input  logic            reset,
	input  logic            mul_load,
	input  logic            step_en,
	input  logic [XLEN-1:0] a,
	input  logic [XLEN-1:0] b,
	input  logic [2:0]      funct3,
	output logic [XLEN-1:0] mul_result
);

	logic              a_signed;
	logic              b_signed;
	logic              a_neg;
	logic              b_neg;
	logic              neg;
	logic              hi_sel;
	logic [XLEN-1:0]   mcand;
	logic [2*XLEN-1:0] acc;
	logic [XLEN:0]     sum;
	logic [2*XLEN-1:0] product;

	// mulhsu treats only a as signed, mulhu neither
	assign a_signed = funct3 != f3_mulhu;
	assign b_signed = funct3 == f3_mul || funct3 == f3_mulh;
	assign a_neg    = a_signed && a[XLEN-1];
	assign b_neg    = b_signed && b[XLEN-1];

	always_ff @(posedge clock) begin
		if (reset) begin
			neg    <= 1'b0;
			hi_sel <= 1'b0;
		end else if (mul_load) begin
			neg    <= a_neg ^ b_neg;
			hi_sel <= funct3 != f3_mul;
		end
	end

	// multiplier magnitude sits in the low half and shifts out as the product shifts in
	always_ff @(posedge clock) begin
		if (mul_load) begin
			mcand <= a_neg ? -a : a;
			acc   <= {{XLEN{1'b0}}, b_neg ? -b : b};
		end else if (step_en) begin
			acc <= {sum, acc[XLEN-1:1]};
		end
	end

	assign sum = {1'b0, acc[2*XLEN-1:XLEN]} + (acc[0] ? {1'b0, mcand} : {(XLEN+1){1'b0}});

	assign product    = neg ? -acc : acc;
	assign mul_result = hi_sel ? product[2*XLEN-1:XLEN] : product[XLEN-1:0];

endmodule

// ==== logic/exu_divider.sv ====
module exu_divider import exu_pkg::*; #(
	parameter int XLEN = 32
) (
	input  logic            clock,
	input  logic            reset,
	input  logic            div_load,
	input  logic            step_en,
	input  logic [XLEN-1:0] a,
	input  logic [XLEN-1:0] b,
	input  logic [2:0]      funct3,
	output logic [XLEN-1:0] div_result
);

	logic            is_signed;
	logic            a_neg;
	logic            b_neg;
	logic            neg_q;
	logic            neg_r;
	logic            b_zero;
	logic            rem_sel;
	logic [XLEN-1:0] divisor;
	logic [XLEN-1:0] quo;
	logic [XLEN-1:0] rem;
	logic [XLEN:0]   trial;
	logic [XLEN-1:0] quo_fix;
	logic [XLEN-1:0] rem_fix;

	assign is_signed = funct3 == f3_div || funct3 == f3_rem;
	assign a_neg     = is_signed && a[XLEN-1];
	assign b_neg     = is_signed && b[XLEN-1];

	always_ff @(posedge clock) begin
		if (reset) begin
			neg_q   <= 1'b0;
			neg_r   <= 1'b0;
			b_zero  <= 1'b0;
			rem_sel <= 1'b0;
		end else if (div_load) begin
			neg_q   <= a_neg ^ b_neg;
			neg_r   <= a_neg; // remainder follows the dividend
			b_zero  <= b == '0;
			rem_sel <= funct3 == f3_rem || funct3 == f3_remu;
		end
	end

	// dividend bits leave quo from the top while quotient bits enter at the bottom
	assign trial = {rem, quo[XLEN-1]} - {1'b0, divisor};

	always_ff @(posedge clock) begin
		if (div_load) begin
			divisor <= b_neg ? -b : b;
			quo     <= a_neg ? -a : a;
			rem     <= '0;
		end else if (step_en) begin
			if (!trial[XLEN]) begin
				rem <= trial[XLEN-1:0];
				quo <= {quo[XLEN-2:0], 1'b1};
			end else begin
				rem <= {rem[XLEN-2:0], quo[XLEN-1]}; // restore, keep the shifted value
				quo <= {quo[XLEN-2:0], 1'b0};
			end
		end
	end

	// Signed overflow needs no special case here. The magnitude quotient of the most
	// negative number by one is that same pattern, and both signs are negative.
	// With a zero divisor every trial succeeds, so the remainder magnitude ends as
	// the dividend magnitude and the sign fix restores a.
	assign quo_fix = b_zero ? {XLEN{1'b1}} : (neg_q ? -quo : quo);
	assign rem_fix = neg_r ? -rem : rem;

	assign div_result = rem_sel ? rem_fix : quo_fix;

endmodule

// ==== logic/exu_top.sv ====
module exu_top import exu_pkg::*; #(
	parameter int XLEN = 32
) (
	input  logic            clock,
	input  logic            reset,
	input  logic            start,
	input  logic            flush,
	input  logic [XLEN-1:0] pc,
	input  logic [XLEN-1:0] src1,
	input  logic [XLEN-1:0] src2,
	input  logic [XLEN-1:0] imm,
	input  src_sel_e        src_sel,
	input  exu_unit_e       unit,
	input  alu_op_e         alu_op,
	input  logic [2:0]      funct3,
	output logic            busy,
	output logic            result_valid,
	output logic [XLEN-1:0] result,
	output logic            zero_flag
);

	localparam int count_width = $clog2(XLEN);

	logic [XLEN-1:0] sel_a;
	logic [XLEN-1:0] sel_b;
	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	alu_op_e         alu_op_q;
	logic [2:0]      funct3_q;
	exu_unit_e       unit_q;
	logic            mul_load;
	logic            div_load;
	logic            count_load;
	logic            step_en;
	logic            capture;
	logic            count_zero;
	logic [XLEN-1:0] alu_result;
	logic [XLEN-1:0] mul_result;
	logic [XLEN-1:0] div_result;

	always_comb begin
		case (src_sel)
			sel_rs1_rs2: begin
				sel_a = src1;
				sel_b = src2;
			end
			sel_rs1_imm: begin
				sel_a = src1;
				sel_b = imm;
			end
			sel_pc_4: begin
				sel_a = pc;
				sel_b = XLEN'(4);
			end
			default: begin
				sel_a = pc;
				sel_b = imm;
			end
		endcase
	end

	// the iterative units load from sel_a/sel_b directly on the same edge
	always_ff @(posedge clock) begin
		if (start && !busy) begin
			op_a     <= sel_a;
			op_b     <= sel_b;
			alu_op_q <= alu_op;
			funct3_q <= funct3;
			unit_q   <= unit;
		end
	end

	always_ff @(posedge clock) begin
		if (capture) begin
			case (unit_q)
				unit_mul: result <= mul_result;
				unit_div: result <= div_result;
				default:  result <= alu_result;
			endcase
		end
	end

	assign zero_flag = result == '0;

	exu_sequencer u_sequencer (
		.clock        (clock),
		.reset        (reset),
		.start        (start),
		.flush        (flush),
		.unit         (unit),
		.count_zero   (count_zero),
		.busy         (busy),
		.result_valid (result_valid),
		.mul_load     (mul_load),
		.div_load     (div_load),
		.count_load   (count_load),
		.step_en      (step_en),
		.capture      (capture)
	);

	exu_step_counter #(
		.XLEN        (XLEN),
		.count_width (count_width)
	) u_step_counter (
		.clock      (clock),
		.reset      (reset),
		.count_load (count_load),
		.step_en    (step_en),
		.count_zero (count_zero)
	);

	exu_alu #(.XLEN(XLEN)) u_alu (
		.a          (op_a),
		.b          (op_b),
		.alu_op     (alu_op_q),
		.funct3     (funct3_q),
		.unit       (unit_q),
		.alu_result (alu_result)
	);

	exu_multiplier #(.XLEN(XLEN)) u_multiplier (
		.clock      (clock),
		.reset      (reset),
		.mul_load   (mul_load),
		.step_en    (step_en),
		.a          (sel_a),
		.b          (sel_b),
		.funct3     (funct3),
		.mul_result (mul_result)
	);

	exu_divider #(.XLEN(XLEN)) u_divider (
		.clock      (clock),
		.reset      (reset),
		.div_load   (div_load),
		.step_en    (step_en),
		.a          (sel_a),
		.b          (sel_b),
		.funct3     (funct3),
		.div_result (div_result)
	);

endmodule

// ==== tb/exu_checker.sv ====
module exu_checker import exu_pkg::*; #(
	parameter int XLEN = 32
) (
	input  logic            clock,
	input  logic            reset,
	input  logic            start,
	input  logic            flush,
	input  logic [XLEN-1:0] pc,
	input  logic [XLEN-1:0] src1,
	input  logic [XLEN-1:0] src2,
	input  logic [XLEN-1:0] imm,
	input  src_sel_e        src_sel,
	input  exu_unit_e       unit,
	input  alu_op_e         alu_op,
	input  logic [2:0]      funct3,
	input  logic            busy,
	input  logic            result_valid,
	input  logic [XLEN-1:0] result,
	input  logic            zero_flag,
	output int              error_count,
	output int              result_count
);

	localparam logic [XLEN-1:0] most_negative = {1'b1, {(XLEN-1){1'b0}}};

	logic            armed = 1'b0;
	logic            model_busy = 1'b0;
	logic            model_valid = 1'b0;
	int              cycles_left = 0;
	int              errors = 0;
	int              results = 0;
	logic [XLEN-1:0] pending_value = '0;
	logic [XLEN-1:0] model_result = '0;
	string           test_name = "reset";
	string           branch_names [8] = '{"beq", "bne", "", "", "blt", "bge", "bltu", "bgeu"};
	string           muldiv_names [8] = '{"mul", "mulh", "mulhsu", "mulhu", "div", "divu", "rem", "remu"};

	assign error_count  = errors;
	assign result_count = results;

	function automatic logic [XLEN-1:0] operand_a();
		return (src_sel == sel_rs1_rs2 || src_sel == sel_rs1_imm) ? src1 : pc;
	endfunction

	function automatic logic [XLEN-1:0] operand_b();
		case (src_sel)
			sel_rs1_rs2: return src2;
			sel_pc_4:    return XLEN'(4);
			default:     return imm;
		endcase
	endfunction

	function automatic logic [XLEN-1:0] alu_model(alu_op_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
		int sh;
		sh = int'(b % XLEN);
		case (op)
			op_add:  return a + b;
			op_sub:  return a - b;
			op_sll:  return a << sh;
			op_slt:  return XLEN'((a ^ most_negative) < (b ^ most_negative)); // signed order by flipping the sign bit
			op_sltu: return XLEN'(a < b);
			op_xor:  return a ^ b;
			op_srl:  return a >> sh;
			op_sra:  return (a >> sh) | (a[XLEN-1] ? ~({XLEN{1'b1}} >> sh) : '0);
			op_or:   return a | b;
			op_and:  return a & b;
			default: return '0;
		endcase
	endfunction

	function automatic logic [XLEN-1:0] branch_model(logic [2:0] f3, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
		logic less_s;
		logic less_u;
		logic taken;
		less_u = a < b;
		less_s = (a ^ most_negative) < (b ^ most_negative);
		case (f3)
			f3_beq:  taken = a == b;
			f3_bne:  taken = a != b;
			f3_blt:  taken = less_s;
			f3_bge:  taken = !less_s;
			f3_bltu: taken = less_u;
			f3_bgeu: taken = !less_u;
			default: taken = 1'b0;
		endcase
		return XLEN'(taken);
	endfunction

	function automatic logic [XLEN-1:0] mul_model(logic [2:0] f3, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
		logic [2*XLEN-1:0] wide_a;
		logic [2*XLEN-1:0] wide_b;
		logic [2*XLEN-1:0] product;
		wide_a  = {{XLEN{a[XLEN-1] && f3 != f3_mulhu}}, a};
		wide_b  = {{XLEN{b[XLEN-1] && (f3 == f3_mul || f3 == f3_mulh)}}, b};
		product = wide_a * wide_b; // extended operands make the truncated product exact
		return (f3 == f3_mul) ? product[XLEN-1:0] : product[2*XLEN-1:XLEN];
	endfunction

	function automatic logic [XLEN-1:0] div_model(logic [2:0] f3, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
		logic            is_signed;
		logic [XLEN-1:0] quotient;
		logic [XLEN-1:0] remainder;
		is_signed = f3 == f3_div || f3 == f3_rem;
		if (b == '0) begin
			quotient  = '1;
			remainder = a;
		end else if (is_signed && a == most_negative && b == '1) begin
			quotient  = a;
			remainder = '0;
		end else if (is_signed) begin
			quotient  = $signed(a) / $signed(b);
			remainder = $signed(a) % $signed(b);
		end else begin
			quotient  = a / b;
			remainder = a % b;
		end
		return (f3 == f3_rem || f3 == f3_remu) ? remainder : quotient;
	endfunction

	task automatic mismatch(string name, logic [XLEN-1:0] expected, logic [XLEN-1:0] actual);
		$display("Fail %s expected %h actual %h", name, expected, actual);
		errors++;
	endtask

	// outputs seen here are the ones from before this edge
	always @(posedge clock) begin
		if (armed) begin
			if (busy !== model_busy)
				mismatch({test_name, " busy"}, XLEN'(model_busy), XLEN'(busy));
			if (result_valid !== model_valid)
				mismatch({test_name, " result_valid"}, XLEN'(model_valid), XLEN'(result_valid));
			if (model_valid && result !== model_result)
				mismatch(test_name, model_result, result);
			if (model_valid && zero_flag !== (model_result == '0))
				mismatch({test_name, " zero_flag"}, XLEN'(model_result == '0), XLEN'(zero_flag));
		end
		if (reset) begin
			armed       = 1'b1;
			model_busy  = 1'b0;
			model_valid = 1'b0;
		end else if (flush) begin
			if (model_busy)
				test_name = {test_name, " flushed"};
			model_busy  = 1'b0;
			model_valid = 1'b0;
		end else if (start && !model_busy) begin
			case (unit)
				unit_alu:    pending_value = alu_model(alu_op, operand_a(), operand_b());
				unit_branch: pending_value = branch_model(funct3, operand_a(), operand_b());
				unit_mul:    pending_value = mul_model(funct3, operand_a(), operand_b());
				default:     pending_value = div_model(funct3, operand_a(), operand_b());
			endcase
			if (unit == unit_alu)
				test_name = {"alu ", alu_op.name()};
			else if (unit == unit_branch)
				test_name = {"branch ", branch_names[funct3]};
			else
				test_name = muldiv_names[funct3];
			cycles_left = (unit == unit_mul || unit == unit_div) ? XLEN + 1 : 1;
			model_busy  = 1'b1;
			model_valid = 1'b0;
		end else if (model_busy) begin
			cycles_left--;
			if (cycles_left == 0) begin
				model_busy   = 1'b0;
				model_valid  = 1'b1;
				model_result = pending_value;
				results++;
			end
		end
	end

endmodule

// ==== tb/exu_tb.sv ====
module exu_tb import exu_pkg::*; ();

	localparam int xlen             = 32;
	localparam int num_instructions = 600;
	localparam int num_directed     = 40; // every alu_op with every src_sel
	localparam int max_cycles       = num_instructions * (xlen + 4) + 100;
	localparam logic [xlen-1:0] most_negative = {1'b1, {(xlen-1){1'b0}}};

	logic            clock;
	logic            reset;
	logic            start;
	logic            flush;
	logic [xlen-1:0] pc;
	logic [xlen-1:0] src1;
	logic [xlen-1:0] src2;
	logic [xlen-1:0] imm;
	src_sel_e        src_sel;
	exu_unit_e       unit;
	alu_op_e         alu_op;
	logic [2:0]      funct3;
	logic            busy;
	logic            result_valid;
	logic [xlen-1:0] result;
	logic            zero_flag;
	int              error_count;
	int              result_count;
	int              cycle_count = 0;
	logic            timed_out = 1'b0;

	exu_top #(.XLEN(xlen)) u_dut (
		.clock        (clock),
		.reset        (reset),
		.start        (start),
		.flush        (flush),
		.pc           (pc),
		.src1         (src1),
		.src2         (src2),
		.imm          (imm),
		.src_sel      (src_sel),
		.unit         (unit),
		.alu_op       (alu_op),
		.funct3       (funct3),
		.busy         (busy),
		.result_valid (result_valid),
		.result       (result),
		.zero_flag    (zero_flag)
	);

	exu_checker #(.XLEN(xlen)) u_checker (
		.clock        (clock),
		.reset        (reset),
		.start        (start),
		.flush        (flush),
		.pc           (pc),
		.src1         (src1),
		.src2         (src2),
		.imm          (imm),
		.src_sel      (src_sel),
		.unit         (unit),
		.alu_op       (alu_op),
		.funct3       (funct3),
		.busy         (busy),
		.result_valid (result_valid),
		.result       (result),
		.zero_flag    (zero_flag),
		.error_count  (error_count),
		.result_count (result_count)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic end_run();
		$display("Results checked %0d, errors %0d, timeouts %0d",
			result_count, error_count, int'(timed_out));
		if (error_count == 0 && !timed_out) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	endtask

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= max_cycles) begin
			$display("Timeout: the run did not end within %0d cycles", max_cycles);
			timed_out = 1'b1;
			end_run();
		end
	end

	// about one word in ten is zero, all ones or the most negative number
	function automatic logic [xlen-1:0] random_word();
		case (int'($urandom % 30))
			0:       return '0;
			1:       return '1;
			2:       return most_negative;
			default: return xlen'({$urandom, $urandom});
		endcase
	endfunction

	task automatic pick_instruction(input int index);
		pc   = random_word();
		src1 = random_word();
		src2 = random_word();
		imm  = random_word();
		alu_op  = alu_op_e'(4'($urandom % 10));
		src_sel = src_sel_e'(2'($urandom % 4));
		if (index < num_directed) begin
			unit    = unit_alu;
			alu_op  = alu_op_e'(4'(index % 10));
			src_sel = src_sel_e'(2'(index / 10));
			funct3  = 3'($urandom % 8);
		end else begin
			unit = exu_unit_e'(2'($urandom % 4));
			case (unit)
				unit_branch: begin
					funct3 = 3'($urandom % 6);
					if (funct3 >= 3'd2)
						funct3 = funct3 + 3'd2; // codes 2 and 3 are not branches
					if ($urandom % 4 == 0) begin
						src_sel = sel_rs1_rs2;
						src2    = src1;
					end
				end
				unit_mul: funct3 = 3'($urandom % 4);
				unit_div: begin
					funct3 = 3'd4 + 3'($urandom % 4);
					if ($urandom % 8 == 0) begin
						src_sel = sel_rs1_rs2;
						src2    = '0;
					end else if ($urandom % 7 == 0) begin
						src_sel = sel_rs1_rs2; // signed overflow case
						src1    = most_negative;
						src2    = '1;
					end
				end
				default: funct3 = 3'($urandom % 8);
			endcase
		end
	endtask

	// called just after a rising edge, with the DUT idle or holding a result
	task automatic run_instruction(input int index);
		int   cycles;
		int   flush_at;
		int   extra_at;
		int   latency;
		logic iterative;
		pick_instruction(index);
		start     = 1'b1;
		iterative = unit == unit_mul || unit == unit_div;
		latency   = iterative ? xlen + 1 : 1;
		flush_at  = -1;
		extra_at  = -1;
		if (iterative && $urandom % 12 == 0)
			flush_at = 1 + int'($urandom % xlen);
		if ($urandom % 10 == 0)
			extra_at = int'($urandom % latency); // lands while the DUT is still busy
		@(posedge clock);
		#1;
		start = 1'b0;
		pick_instruction(num_directed); // inputs only matter on the start cycle
		cycles = 0;
		while (!result_valid) begin
			if (cycles == flush_at)
				flush = 1'b1;
			if (cycles == extra_at) begin
				pick_instruction(num_directed);
				start = 1'b1;
			end
			@(posedge clock);
			#1;
			start = 1'b0;
			flush = 1'b0;
			if (cycles == flush_at)
				break;
			cycles++;
		end
		repeat (int'($urandom % 3)) begin
			@(posedge clock);
			#1;
		end
	endtask

	initial begin
		int seed_value;
		seed_value = $urandom(84);
		reset   = 1'b1;
		start   = 1'b0;
		flush   = 1'b0;
		pc      = '0;
		src1    = '0;
		src2    = '0;
		imm     = '0;
		src_sel = sel_rs1_rs2;
		unit    = unit_alu;
		alu_op  = op_add;
		funct3  = 3'd0;
		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;
		@(posedge clock); // one idle cycle before the first start
		#1;
		for (int i = 0; i < num_instructions; i++) begin
			run_instruction(i);
		end
		repeat (2) begin
			@(posedge clock);
			#1;
		end
		end_run();
	end

endmodule

// ==== all.f ====
logic/exu_pkg.sv
logic/exu_alu.sv
logic/exu_sequencer.sv
logic/exu_step_counter.sv
logic/exu_multiplier.sv
logic/exu_divider.sv
logic/exu_top.sv
tb/exu_checker.sv
tb/exu_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary -f all.f --top-module exu_tb -o exu_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/exu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
	exit 1
fi
exit 0
